//--- sources.f
design/axi_merge_pkg.sv
design/wr_chan_if.sv
design/sync_fifo.sv
design/wr_port_intake.sv
design/wr_burst_arbiter.sv
design/wr_resp_router.sv
design/axi_wr_merger.sv
test/axi_wr_merger_assert.sv
test/tb_axi_wr_merger.sv

//--- Bender.yml
package:
  name: axi_wr_merger

sources:
  - files:
      - design/axi_merge_pkg.sv
      - design/wr_chan_if.sv
      - design/sync_fifo.sv
      - design/wr_port_intake.sv
      - design/wr_burst_arbiter.sv
      - design/wr_resp_router.sv
      - design/axi_wr_merger.sv
  - target: test
    files:
      - test/axi_wr_merger_assert.sv
      - test/tb_axi_wr_merger.sv

//--- test/tb_axi_wr_merger.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_wr_merger;
    import axi_merge_pkg::*;

    localparam int NP      = 4;
    localparam int ID_W    = 4;
    localparam int DATA_W  = 64;
    localparam int MAX_OUT = 8;
    localparam int MAX_REQ = 32;
    localparam int LIMIT   = 4000; // cycles per wait.

    logic                clk;
    logic                rst_n;
    logic [ID_W-1:0]     s_awid    [NP];
    logic [ADDR_W-1:0]   s_awaddr  [NP];
    logic [LEN_W-1:0]    s_awlen   [NP];
    burst_e              s_awburst [NP];
    logic                s_awvalid [NP];
    logic                s_awready [NP];
    logic [DATA_W-1:0]   s_wdata   [NP];
    logic [DATA_W/8-1:0] s_wstrb   [NP];
    logic                s_wlast   [NP];
    logic                s_wvalid  [NP];
    logic                s_wready  [NP];
    logic [ID_W-1:0]     s_bid     [NP];
    logic [RESP_W-1:0]   s_bresp   [NP];
    logic                s_bvalid  [NP];
    logic                s_bready  [NP];
    logic [ID_W-1:0]     m_awid;
    logic [ADDR_W-1:0]   m_awaddr;
    logic [LEN_W-1:0]    m_awlen;
    burst_e              m_awburst;
    logic                m_awvalid;
    logic                m_awready;
    logic [DATA_W-1:0]   m_wdata;
    logic [DATA_W/8-1:0] m_wstrb;
    logic                m_wlast;
    logic                m_wvalid;
    logic                m_wready;
    logic [ID_W-1:0]     m_bid;
    logic [RESP_W-1:0]   m_bresp;
    logic                m_bvalid;
    logic                m_bready;

    integer              seed;
    int                  errors;
    int                  timeouts;
    bit                  hold_b;     // slave withholds responses.
    bit                  hold_port0; // port 0 refuses its response.
    logic [ID_W-1:0]     req_id    [NP][MAX_REQ];
    logic [ADDR_W-1:0]   req_addr  [NP][MAX_REQ];
    logic [LEN_W-1:0]    req_len   [NP][MAX_REQ];
    burst_e              req_burst [NP][MAX_REQ];
    int                  sent [NP];
    int                  fwd  [NP];
    int                  done [NP];
    int                  cur_p;
    int                  cur_r;
    int                  cur_beat;
    logic [ID_W+RESP_W-1:0] burst_tag;
    logic [ID_W+RESP_W-1:0] b_q [$];
    bit                  b_fire;
    bit                  stall_v    [NP];
    logic [ID_W-1:0]     stall_id   [NP];
    logic [RESP_W-1:0]   stall_resp [NP];

    axi_wr_merger dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // slverr for the upper half of the address space.
    function automatic logic [RESP_W-1:0] expect_resp(input logic [ADDR_W-1:0] addr);
        return addr[31] ? 2'b10 : 2'b00;
    endfunction

    function automatic logic [DATA_W-1:0] beat_word(input int p, input int r, input int b);
        return {8'(p), 24'h0, 16'(r), 16'(b)}; // port, request, beat.
    endfunction

    function automatic logic [DATA_W/8-1:0] beat_strb(input int p, input int r, input int b);
        return 8'(r * 16 + p * 4 + b) ^ 8'h5a; // differs per beat.
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("Error %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic wait_ready(input int p, input bit data_ch);
        int n;
        bit rdy;
        n = 0;
        rdy = 1'b0;
        while (!rdy && n < LIMIT) begin
            @(negedge clk);
            rdy = data_ch ? s_wready[p] : s_awready[p];
            n++;
        end
        if (!rdy) begin
            timeouts++;
            $display("port %0d never accepted its %s", p, data_ch ? "data" : "address");
        end
    endtask

    task automatic send_req(input int p);
        int r;
        r = sent[p];
        sent[p]++;
        req_id[p][r]    = ID_W'($random(seed));
        req_addr[p][r]  = $random(seed);
        req_len[p][r]   = LEN_W'($random(seed) & 3);
        req_burst[p][r] = burst_e'(2'(($random(seed) & 32'hffff) % 3));
        @(posedge clk);
        s_awid[p]    <= req_id[p][r];
        s_awaddr[p]  <= req_addr[p][r];
        s_awlen[p]   <= req_len[p][r];
        s_awburst[p] <= req_burst[p][r];
        s_awvalid[p] <= 1'b1;
        wait_ready(p, 1'b0);
        @(posedge clk);
        s_awvalid[p] <= 1'b0;
        for (int b = 0; b <= int'(req_len[p][r]); b++) begin
            s_wdata[p]  <= beat_word(p, r, b);
            s_wstrb[p]  <= beat_strb(p, r, b);
            s_wlast[p]  <= (b == int'(req_len[p][r]));
            s_wvalid[p] <= 1'b1;
            wait_ready(p, 1'b1);
            @(posedge clk);
        end
        s_wvalid[p] <= 1'b0;
    endtask

    task automatic load_port(input int p, input int n);
        for (int i = 0; i < n; i++) send_req(p);
    endtask

    function automatic bit all_answered();
        for (int p = 0; p < NP; p++) begin
            if (done[p] != sent[p]) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic wait_idle(input string what);
        int n;
        n = 0;
        while (!all_answered() && n < LIMIT && timeouts == 0) begin
            @(negedge clk);
            n++;
        end
        if (!all_answered()) begin
            timeouts++;
            $display("%s: responses still missing when the wait ran out", what);
        end
    endtask

    task automatic release_responses();
        int n;
        int busiest;
        n = 0;
        busiest = 0;
        while (busiest < MAX_OUT && n < LIMIT && timeouts == 0) begin
            @(negedge clk);
            n++;
            busiest = 0;
            for (int p = 0; p < NP; p++) begin
                if (fwd[p] - done[p] > busiest) busiest = fwd[p] - done[p];
            end
        end
        if (busiest < MAX_OUT) begin
            timeouts++;
            $display("no port reached the outstanding limit while responses were held");
        end
        repeat (20) @(negedge clk); // forwarding must stay stalled here.
        hold_b = 1'b0;
    endtask

    task automatic stall_port0();
        int n;
        n = 0;
        while (!s_bvalid[0] && n < LIMIT && timeouts == 0) begin
            @(negedge clk);
            n++;
        end
        if (!s_bvalid[0]) begin
            timeouts++;
            $display("port 0 never saw its response");
        end
        repeat (10) @(negedge clk);
        hold_port0 = 1'b0;
    endtask

    // downstream slave.
    always @(negedge clk) begin
        b_fire = m_bvalid && m_bready;
        if (rst_n && m_awvalid) burst_tag = {m_awid, m_awaddr[31] ? 2'b10 : 2'b00};
        if (rst_n && m_wvalid && m_wlast) b_q.push_back(burst_tag);
    end

    always @(posedge clk) begin
        if (b_fire) void'(b_q.pop_front());
        if (!m_bvalid || b_fire) begin
            if (!hold_b && b_q.size() > 0 && ($random(seed) & 1)) begin
                m_bvalid <= 1'b1;
                {m_bid, m_bresp} <= b_q[0];
            end else begin
                m_bvalid <= 1'b0;
            end
        end
        m_awready <= ($random(seed) & 3) != 0;
        m_wready  <= ($random(seed) & 3) != 0;
        for (int p = 0; p < NP; p++) begin
            s_bready[p] <= (hold_port0 && p == 0) ? 1'b0 : (($random(seed) & 3) != 0);
        end
    end

    always @(negedge clk) begin : monitor
        int r;
        if (rst_n) begin
            if (m_awvalid) begin
                if (m_awid < NP && fwd[m_awid] < sent[m_awid]) begin
                    cur_p = m_awid;
                    cur_r = fwd[cur_p];
                    cur_beat = 0;
                    check("m_awaddr", req_addr[cur_p][cur_r], m_awaddr);
                    check("m_awlen", req_len[cur_p][cur_r], m_awlen);
                    check("m_awburst", req_burst[cur_p][cur_r], m_awburst);
                    fwd[cur_p]++;
                    check("outstanding within limit", 1, fwd[cur_p] - done[cur_p] <= MAX_OUT);
                end else begin
                    errors++;
                    $display("address with id %0d matches no waiting request", m_awid);
                end
            end
            if (m_wvalid) begin
                check("m_wdata", beat_word(cur_p, cur_r, cur_beat), m_wdata);
                check("m_wstrb", beat_strb(cur_p, cur_r, cur_beat), m_wstrb);
                check("m_wlast", cur_beat == int'(req_len[cur_p][cur_r]), m_wlast);
                cur_beat++;
            end
            for (int p = 0; p < NP; p++) begin
                if (stall_v[p]) begin
                    check("s_bvalid held", 1, s_bvalid[p]);
                    check("s_bid held", stall_id[p], s_bid[p]);
                    check("s_bresp held", stall_resp[p], s_bresp[p]);
                end
                stall_v[p] = s_bvalid[p] && !s_bready[p];
                stall_id[p] = s_bid[p];
                stall_resp[p] = s_bresp[p];
                if (s_bvalid[p] && s_bready[p]) begin
                    r = done[p]; // responses come back in issue order.
                    check("response for a forwarded request", 1, r < fwd[p]);
                    check("s_bid", req_id[p][r], s_bid[p]);
                    check("s_bresp", expect_resp(req_addr[p][r]), s_bresp[p]);
                    done[p]++;
                end
            end
        end
    end

    initial begin
        seed = 72;
        errors = 0;
        timeouts = 0;
        hold_b = 1'b0;
        hold_port0 = 1'b0;
        b_fire = 1'b0;
        rst_n = 1'b0;
        m_awready = 1'b0;
        m_wready = 1'b0;
        m_bvalid = 1'b0;
        m_bid = '0;
        m_bresp = '0;
        burst_tag = '0;
        for (int p = 0; p < NP; p++) begin
            s_awid[p] = '0;
            s_awaddr[p] = '0;
            s_awlen[p] = '0;
            s_awburst[p] = BURST_INCR;
            s_awvalid[p] = 1'b0;
            s_wdata[p] = '0;
            s_wstrb[p] = '0;
            s_wlast[p] = 1'b0;
            s_wvalid[p] = 1'b0;
            s_bready[p] = 1'b0;
            sent[p] = 0;
            fwd[p] = 0;
            done[p] = 0;
            stall_v[p] = 1'b0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int p = 0; p < NP; p++) begin
            load_port(p, 1);
            wait_idle("single write");
        end
        fork
            load_port(0, 12);
            load_port(1, 12);
            load_port(2, 12);
            load_port(3, 12);
        join
        wait_idle("full load");
        hold_b = 1'b1;
        fork
            load_port(0, 10);
            load_port(1, 10);
            load_port(2, 10);
            load_port(3, 10);
            release_responses();
        join
        wait_idle("held responses");
        hold_port0 = 1'b1;
        fork
            load_port(0, 1);
            load_port(1, 1);
            load_port(2, 1);
            load_port(3, 1);
            stall_port0();
        join
        wait_idle("stalled port");
        for (int p = 0; p < NP; p++) check("requests forwarded", sent[p], fwd[p]);
        $display("check errors %0d, assertion errors %0d, timeouts %0d",
                 errors, dut.u_assert.err_count, timeouts);
        if (errors == 0 && timeouts == 0 && dut.u_assert.err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/axi_wr_merger_assert.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wr_merger_assert #(
    parameter int NUM_PORTS = 4,
    parameter int ID_W      = 4
) (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             m_awvalid,
    input logic                             m_awready,
    input logic                             m_wvalid,
    input logic                             m_wready,
    input logic                             m_wlast,
    input logic [ID_W-1:0]                  s_bid    [NUM_PORTS],
    input logic [axi_merge_pkg::RESP_W-1:0] s_bresp  [NUM_PORTS],
    input logic                             s_bvalid [NUM_PORTS],
    input logic                             s_bready [NUM_PORTS]
);

    int   err_count = 0;
    logic in_burst;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) in_burst <= 1'b0;
        else if (m_wvalid) in_burst <= !m_wlast; // open until the last beat.
    end

    assert property (@(posedge clk) disable iff (!rst_n) m_awvalid |-> m_awready)
        else begin err_count++; $error("m_awvalid raised without m_awready"); end

    assert property (@(posedge clk) disable iff (!rst_n) m_wvalid |-> m_wready)
        else begin err_count++; $error("m_wvalid raised without m_wready"); end

    assert property (@(posedge clk) disable iff (!rst_n) in_burst |-> !m_awvalid)
        else begin err_count++; $error("new address issued inside an open burst"); end

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        assert property (@(posedge clk) disable iff (!rst_n)
            s_bvalid[i] && !s_bready[i] |=>
                s_bvalid[i] && $stable(s_bid[i]) && $stable(s_bresp[i]))
            else begin err_count++; $error("port %0d response changed while stalled", i); end
    end

endmodule

bind axi_wr_merger axi_wr_merger_assert #(.NUM_PORTS(NUM_PORTS), .ID_W(ID_W)) u_assert (
    .clk(clk), .rst_n(rst_n), .m_awvalid(m_awvalid), .m_awready(m_awready),
    .m_wvalid(m_wvalid), .m_wready(m_wready), .m_wlast(m_wlast),
    .s_bid(s_bid), .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready)
);

`default_nettype wire

//--- design/axi_wr_merger.sv
`timescale 1ns/1ps
`default_nettype none

module axi_wr_merger #(
    parameter int NUM_PORTS       = 4,
    parameter int ID_W            = 4,
    parameter int DATA_W          = 64,
    parameter int MAX_OUTSTANDING = 8
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [ID_W-1:0]                  s_awid    [NUM_PORTS],
    input  logic [axi_merge_pkg::ADDR_W-1:0] s_awaddr  [NUM_PORTS],
    input  logic [axi_merge_pkg::LEN_W-1:0]  s_awlen   [NUM_PORTS],
    input  axi_merge_pkg::burst_e            s_awburst [NUM_PORTS],
    input  logic                             s_awvalid [NUM_PORTS],
    output logic                             s_awready [NUM_PORTS],
    input  logic [DATA_W-1:0]                s_wdata   [NUM_PORTS],
    input  logic [DATA_W/8-1:0]              s_wstrb   [NUM_PORTS],
    input  logic                             s_wlast   [NUM_PORTS],
    input  logic                             s_wvalid  [NUM_PORTS],
    output logic                             s_wready  [NUM_PORTS],
    output logic [ID_W-1:0]                  s_bid     [NUM_PORTS],
    output logic [axi_merge_pkg::RESP_W-1:0] s_bresp   [NUM_PORTS],
    output logic                             s_bvalid  [NUM_PORTS],
    input  logic                             s_bready  [NUM_PORTS],
    output logic [ID_W-1:0]                  m_awid,
    output logic [axi_merge_pkg::ADDR_W-1:0] m_awaddr,
    output logic [axi_merge_pkg::LEN_W-1:0]  m_awlen,
    output axi_merge_pkg::burst_e            m_awburst,
    output logic                             m_awvalid,
    input  logic                             m_awready,
    output logic [DATA_W-1:0]                m_wdata,
    output logic [DATA_W/8-1:0]              m_wstrb,
    output logic                             m_wlast,
    output logic                             m_wvalid,
    input  logic                             m_wready,
    input  logic [ID_W-1:0]                  m_bid,
    input  logic [axi_merge_pkg::RESP_W-1:0] m_bresp,
    input  logic                             m_bvalid,
    output logic                             m_bready
);

    logic                         issue_valid;
    logic [$clog2(NUM_PORTS)-1:0] issue_port;
    logic [ID_W-1:0]              issue_id;
    logic [NUM_PORTS-1:0]         resp_done;

    wr_chan_if #(.DATA_W(DATA_W)) chan [NUM_PORTS] ();

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_intake
        wr_port_intake #(.ID_W(ID_W), .DATA_W(DATA_W)) u_intake (
            .clk(clk), .rst_n(rst_n),
            .awid(s_awid[i]), .awaddr(s_awaddr[i]), .awlen(s_awlen[i]),
            .awburst(s_awburst[i]), .awvalid(s_awvalid[i]), .awready(s_awready[i]),
            .wdata(s_wdata[i]), .wstrb(s_wstrb[i]), .wlast(s_wlast[i]),
            .wvalid(s_wvalid[i]), .wready(s_wready[i]),
            .chan(chan[i])
        );
    end

    wr_burst_arbiter #(
        .NUM_PORTS(NUM_PORTS), .ID_W(ID_W), .DATA_W(DATA_W),
        .MAX_OUTSTANDING(MAX_OUTSTANDING)
    ) u_arbiter (
        .clk(clk), .rst_n(rst_n), .chan(chan),
        .m_awid(m_awid), .m_awaddr(m_awaddr), .m_awlen(m_awlen), .m_awburst(m_awburst),
        .m_awvalid(m_awvalid), .m_awready(m_awready),
        .m_wdata(m_wdata), .m_wstrb(m_wstrb), .m_wlast(m_wlast),
        .m_wvalid(m_wvalid), .m_wready(m_wready),
        .issue_valid(issue_valid), .issue_port(issue_port), .issue_id(issue_id),
        .resp_done(resp_done)
    );

    wr_resp_router #(
        .NUM_PORTS(NUM_PORTS), .ID_W(ID_W), .MAX_OUTSTANDING(MAX_OUTSTANDING)
    ) u_router (
        .clk(clk), .rst_n(rst_n),
        .issue_valid(issue_valid), .issue_port(issue_port), .issue_id(issue_id),
        .m_bid(m_bid), .m_bresp(m_bresp), .m_bvalid(m_bvalid), .m_bready(m_bready),
        .s_bid(s_bid), .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
        .resp_done(resp_done)
    );

endmodule

`default_nettype wire

//--- design/wr_resp_router.sv
`timescale 1ns/1ps
`default_nettype none

module wr_resp_router #(
    parameter int NUM_PORTS       = 4,
    parameter int ID_W            = 4,
    parameter int MAX_OUTSTANDING = 8
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             issue_valid,
    input  logic [$clog2(NUM_PORTS)-1:0]     issue_port,
    input  logic [ID_W-1:0]                  issue_id,
    input  logic [ID_W-1:0]                  m_bid,
    input  logic [axi_merge_pkg::RESP_W-1:0] m_bresp,
    input  logic                             m_bvalid,
    output logic                             m_bready,
    output logic [ID_W-1:0]                  s_bid    [NUM_PORTS],
    output logic [axi_merge_pkg::RESP_W-1:0] s_bresp  [NUM_PORTS],
    output logic                             s_bvalid [NUM_PORTS],
    input  logic                             s_bready [NUM_PORTS],
    output logic [NUM_PORTS-1:0]             resp_done
);
    import axi_merge_pkg::*;

    localparam int PORT_W = $clog2(NUM_PORTS);

    logic [ID_W+RESP_W-1:0] rsp_head;
    logic [ID_W-1:0]        rsp_tag;
    logic [RESP_W-1:0]      rsp_resp;
    logic                   rsp_empty;
    logic                   rsp_full;

    assign m_bready = !rsp_full;
    assign {rsp_tag, rsp_resp} = rsp_head;

    sync_fifo #(.WIDTH(ID_W + RESP_W), .DEPTH(2)) u_rsp_fifo (
        .clk(clk), .rst_n(rst_n),
        .push(m_bvalid && m_bready), .din({m_bid, m_bresp}),
        .pop(|resp_done), .dout(rsp_head),
        .empty(rsp_empty), .full(rsp_full)
    );

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        // original ids in issue order.
        sync_fifo #(.WIDTH(ID_W), .DEPTH(MAX_OUTSTANDING)) u_id_fifo (
            .clk(clk), .rst_n(rst_n),
            .push(issue_valid && issue_port == PORT_W'(i)), .din(issue_id),
            .pop(resp_done[i]), .dout(s_bid[i]),
            .empty(), .full()
        );

        assign s_bvalid[i]  = !rsp_empty && (rsp_tag == ID_W'(i));
        assign s_bresp[i]   = rsp_resp;
        assign resp_done[i] = s_bvalid[i] && s_bready[i];
    end

endmodule

`default_nettype wire

//--- design/wr_burst_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wr_burst_arbiter #(
    parameter int NUM_PORTS       = 4,
    parameter int ID_W            = 4,
    parameter int DATA_W          = 64,
    parameter int MAX_OUTSTANDING = 8
) (
    input  logic                             clk,
    input  logic                             rst_n,
    wr_chan_if.arbiter                       chan [NUM_PORTS],
    output logic [ID_W-1:0]                  m_awid,
    output logic [axi_merge_pkg::ADDR_W-1:0] m_awaddr,
    output logic [axi_merge_pkg::LEN_W-1:0]  m_awlen,
    output axi_merge_pkg::burst_e            m_awburst,
    output logic                             m_awvalid,
    input  logic                             m_awready,
    output logic [DATA_W-1:0]                m_wdata,
    output logic [DATA_W/8-1:0]              m_wstrb,
    output logic                             m_wlast,
    output logic                             m_wvalid,
    input  logic                             m_wready,
    output logic                             issue_valid,
    output logic [$clog2(NUM_PORTS)-1:0]     issue_port,
    output logic [ID_W-1:0]                  issue_id,
    input  logic [NUM_PORTS-1:0]             resp_done
);
    import axi_merge_pkg::*;

    localparam int PORT_W = $clog2(NUM_PORTS);
    localparam int CNT_W  = $clog2(MAX_OUTSTANDING + 1);

    logic                aw_valid [NUM_PORTS];
    aw_entry_t           aw_entry [NUM_PORTS];
    logic                w_valid  [NUM_PORTS];
    logic [DATA_W-1:0]   w_data   [NUM_PORTS];
    logic [DATA_W/8-1:0] w_strb   [NUM_PORTS];
    logic                w_last   [NUM_PORTS];
    logic [7:0]          age      [NUM_PORTS];
    logic [CNT_W-1:0]    pending  [NUM_PORTS];
    logic [PORT_W-1:0]   win_idx;
    logic [7:0]          win_age;
    logic [PORT_W-1:0]   owner;
    logic [PORT_W-1:0]   cur_port;
    arb_state_e          state;
    logic                issue;
    logic                w_go;

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        assign aw_valid[i]   = chan[i].aw_valid;
        assign aw_entry[i]   = chan[i].aw_entry;
        assign w_valid[i]    = chan[i].w_valid;
        assign w_data[i]     = chan[i].w_data;
        assign w_strb[i]     = chan[i].w_strb;
        assign w_last[i]     = chan[i].w_last;
        assign chan[i].aw_pop = issue && (win_idx == PORT_W'(i));
        assign chan[i].w_pop  = w_go && (cur_port == PORT_W'(i));
    end

    // oldest eligible port, lowest index on a tie.
    always_comb begin
        win_idx = '0;
        win_age = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (aw_valid[i] && w_valid[i] && age[i] > win_age) begin
                win_idx = PORT_W'(i);
                win_age = age[i];
            end
        end
    end

    assign issue = (state == ARB_IDLE) && (win_age != '0) && m_awready && m_wready &&
                   (pending[win_idx] < CNT_W'(MAX_OUTSTANDING));
    assign cur_port = (state == ARB_BURST) ? owner : win_idx;
    assign w_go = issue || ((state == ARB_BURST) && m_wready && w_valid[owner]);

    assign m_awvalid = issue;
    assign m_awid    = ID_W'(win_idx); // port index replaces the id.
    assign m_awaddr  = aw_entry[win_idx].addr;
    assign m_awlen   = aw_entry[win_idx].len;
    assign m_awburst = aw_entry[win_idx].burst;
    assign m_wvalid  = w_go;
    assign m_wdata   = w_data[cur_port];
    assign m_wstrb   = w_strb[cur_port];
    assign m_wlast   = w_last[cur_port];

    assign issue_valid = issue;
    assign issue_port  = win_idx;
    assign issue_id    = aw_entry[win_idx].id[ID_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
            owner <= '0;
        end else if (issue && aw_entry[win_idx].len != '0) begin
            state <= ARB_BURST; // more beats to follow.
            owner <= win_idx;
        end else if (state == ARB_BURST && m_wvalid && m_wlast) begin
            state <= ARB_IDLE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                age[i]     <= '0;
                pending[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (issue && win_idx == PORT_W'(i)) age[i] <= '0;
                else if (aw_valid[i] && w_valid[i] && age[i] != 8'hff) age[i] <= age[i] + 8'd1;
                if (issue && win_idx == PORT_W'(i) && !resp_done[i]) begin
                    pending[i] <= pending[i] + 1'b1;
                end else if (resp_done[i] && !(issue && win_idx == PORT_W'(i))) begin
                    pending[i] <= pending[i] - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/wr_port_intake.sv
`timescale 1ns/1ps
`default_nettype none

module wr_port_intake #(
    parameter int ID_W   = 4,
    parameter int DATA_W = 64
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [ID_W-1:0]                  awid,
    input  logic [axi_merge_pkg::ADDR_W-1:0] awaddr,
    input  logic [axi_merge_pkg::LEN_W-1:0]  awlen,
    input  axi_merge_pkg::burst_e            awburst,
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [DATA_W-1:0]                wdata,
    input  logic [DATA_W/8-1:0]              wstrb,
    input  logic                             wlast,
    input  logic                             wvalid,
    output logic                             wready,
    wr_chan_if.intake                        chan
);
    import axi_merge_pkg::*;

    localparam int STRB_W = DATA_W / 8;
    localparam int W_ENTRY_W = DATA_W + STRB_W + 1;

    aw_entry_t              aw_in;
    logic                   aw_full;
    logic                   aw_empty;
    logic [W_ENTRY_W-1:0]   w_head;
    logic                   w_full;
    logic                   w_empty;

    assign aw_in = '{id: ID_MAX_W'(awid), addr: awaddr, len: awlen, burst: awburst};
    assign awready = !aw_full;
    assign wready  = !w_full;

    sync_fifo #(.WIDTH($bits(aw_entry_t)), .DEPTH(2)) u_aw_fifo (
        .clk(clk), .rst_n(rst_n),
        .push(awvalid && awready), .din(aw_in),
        .pop(chan.aw_pop), .dout(chan.aw_entry),
        .empty(aw_empty), .full(aw_full)
    );

    sync_fifo #(.WIDTH(W_ENTRY_W), .DEPTH(2)) u_w_fifo (
        .clk(clk), .rst_n(rst_n),
        .push(wvalid && wready), .din({wlast, wstrb, wdata}),
        .pop(chan.w_pop), .dout(w_head),
        .empty(w_empty), .full(w_full)
    );

    assign chan.aw_valid = !aw_empty;
    assign chan.w_valid  = !w_empty;
    assign {chan.w_last, chan.w_strb, chan.w_data} = w_head; // last, strobe, data.

endmodule

`default_nettype wire

//--- design/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] din,
    input  logic             pop,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full; // dropped when full.
    assign do_pop  = pop && !empty;
    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(DEPTH));
    assign dout    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= din;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- design/wr_chan_if.sv
`timescale 1ns/1ps
`default_nettype none

interface wr_chan_if #(
    parameter int DATA_W = 64
);
    import axi_merge_pkg::*;

    logic                  aw_valid;
    aw_entry_t             aw_entry;
    logic                  aw_pop;
    logic                  w_valid;
    logic [DATA_W-1:0]     w_data;
    logic [DATA_W/8-1:0]   w_strb;
    logic                  w_last;
    logic                  w_pop;

    modport intake (output aw_valid, aw_entry, w_valid, w_data, w_strb, w_last,
                    input aw_pop, w_pop);

    modport arbiter (input aw_valid, aw_entry, w_valid, w_data, w_strb, w_last,
                     output aw_pop, w_pop);

endinterface

`default_nettype wire

//--- design/axi_merge_pkg.sv
`default_nettype none

package axi_merge_pkg;

    localparam int ADDR_W = 32;
    localparam int LEN_W = 8; // beats = len + 1.
    localparam int RESP_W = 2;
    localparam int ID_MAX_W = 8; // widest id a queue entry holds.

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_e;

    // one queued address request, 50 bits.
    typedef struct packed {
        logic [ID_MAX_W-1:0] id; // original id, zero extended.
        logic [ADDR_W-1:0]   addr;
        logic [LEN_W-1:0]    len;
        burst_e              burst;
    } aw_entry_t;

    typedef enum logic {
        ARB_IDLE  = 1'b0,
        ARB_BURST = 1'b1
    } arb_state_e;

endpackage

`default_nettype wire
